/* hw/fp_adder.sv */
module fp_adder #(
    parameter int LATENCY = 1
) (
    input  logic clk_in,
    input  logic rst_N_in,
    input  logic flush_in,
    fpu_if.unit  bus
);

    logic [LATENCY-1:0]            vld_q;
    logic [reg_pkg::WORD_SIZE-1:0] sum_q [LATENCY];

    // valid chain, cleared by flush
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            vld_q <= '0;
        end else if (flush_in) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= bus.start;
            for (int i = 1; i < LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // wrapping sum, Q16.16 needs no alignment
    always_ff @(posedge clk_in) begin
        sum_q[0] <= bus.a + bus.b;
        for (int i = 1; i < LATENCY; i++) begin
            sum_q[i] <= sum_q[i-1];
        end
    end

    assign bus.result       = sum_q[LATENCY-1];
    assign bus.result_valid = vld_q[LATENCY-1];

    a_add_latency: assert property (@(posedge clk_in) disable iff (!rst_N_in || flush_in)
        bus.start |-> ##LATENCY bus.result_valid);

endmodule

/* hw/fp_dispatch.sv */
module fp_dispatch #(
    parameter int FP_ADD_LATENCY  = 1,
    parameter int FP_MULT_LATENCY = 4
) (
    input  logic                   clk_in,
    input  logic                   rst_N_in,
    input  logic                   flush_in,
    input  uop_pkg::exec_packet    insn_in,
    output logic                   ready_out,
    fpu_if.dispatch                add_bus,
    fpu_if.dispatch                mult_bus,
    output reg_pkg::reg_write_port wb_pkt
);

    logic               is_fadd;
    logic               is_fsub;
    logic               is_fmul;
    logic               is_fp;
    logic               accept;
    logic               busy;
    logic               sel_mult;
    logic               unit_valid;
    logic               done;
    reg_pkg::preg_idx_t dest_q;

    // decode
    assign is_fadd = insn_in.valid && (insn_in.uopcode == uop_pkg::UOP_FADD);
    assign is_fsub = insn_in.valid && (insn_in.uopcode == uop_pkg::UOP_FSUB);
    assign is_fmul = insn_in.valid && (insn_in.uopcode == uop_pkg::UOP_FMUL);
    assign is_fp   = is_fadd || is_fsub || is_fmul;

    // only one instruction in flight
    assign accept    = is_fp && !busy && !flush_in;
    assign ready_out = !busy;

    // subtraction goes through the adder with b negated
    assign add_bus.a     = insn_in.r1_val;
    assign add_bus.b     = is_fsub ? (~insn_in.r2_val + 1) : insn_in.r2_val;
    assign add_bus.start = accept && (is_fadd || is_fsub);

    assign mult_bus.a     = insn_in.r1_val;
    assign mult_bus.b     = insn_in.r2_val;
    assign mult_bus.start = accept && is_fmul;

    assign unit_valid = sel_mult ? mult_bus.result_valid : add_bus.result_valid;
    assign done       = busy && unit_valid;

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            busy     <= 1'b0;
            sel_mult <= 1'b0;
        end else if (flush_in) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy     <= 1'b1;
            sel_mult <= is_fmul;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            dest_q <= insn_in.dest_reg_phys;
        end
    end

    // writeback is suppressed when the same cycle flushes
    always_comb begin
        wb_pkt = '0;
        if (done && !flush_in) begin
            wb_pkt.en    = 1'b1;
            wb_pkt.index = dest_q;
            wb_pkt.data  = sel_mult ? mult_bus.result : add_bus.result;
        end
    end

    a_no_issue_while_busy: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        !(is_fp && busy));

    a_no_result_while_idle: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        (add_bus.result_valid || mult_bus.result_valid) |-> busy);

    // units must answer within the latency this dispatcher was built for
    a_add_bounded: assert property (@(posedge clk_in) disable iff (!rst_N_in || flush_in)
        add_bus.start |-> ##[1:FP_ADD_LATENCY] add_bus.result_valid);

    a_mult_bounded: assert property (@(posedge clk_in) disable iff (!rst_N_in || flush_in)
        mult_bus.start |-> ##[1:FP_MULT_LATENCY] mult_bus.result_valid);

endmodule

/* hw/fp_exec_unit.sv */
module fp_exec_unit #(
    parameter int FP_ADD_LATENCY  = 1,
    parameter int FP_MULT_LATENCY = 4
) (
    input  logic                          clk_in,
    input  logic                          rst_N_in,
    input  logic                          flush_in,

    // issue
    input  logic                          insn_valid,
    input  uop_pkg::uop_e                 insn_op,
    input  reg_pkg::preg_idx_t            insn_dest,
    input  logic [reg_pkg::WORD_SIZE-1:0] insn_r1_val,
    input  logic [reg_pkg::WORD_SIZE-1:0] insn_r2_val,
    output logic                          ready_out,

    // writeback mirror
    output logic                          wb_en,
    output reg_pkg::preg_idx_t            wb_index,
    output logic [reg_pkg::WORD_SIZE-1:0] wb_data,

    // read port
    input  reg_pkg::preg_idx_t            rd_index,
    output logic [reg_pkg::WORD_SIZE-1:0] rd_data
);

    uop_pkg::exec_packet    insn_pkt;
    reg_pkg::reg_write_port wb_pkt;

    fpu_if add_bus ();
    fpu_if mult_bus ();

    assign insn_pkt.valid         = insn_valid;
    assign insn_pkt.uopcode       = insn_op;
    assign insn_pkt.dest_reg_phys = insn_dest;
    assign insn_pkt.r1_val        = insn_r1_val;
    assign insn_pkt.r2_val        = insn_r2_val;

    assign wb_en    = wb_pkt.en;
    assign wb_index = wb_pkt.index;
    assign wb_data  = wb_pkt.data;

    fp_dispatch #(
        .FP_ADD_LATENCY  (FP_ADD_LATENCY),
        .FP_MULT_LATENCY (FP_MULT_LATENCY)
    ) u_dispatch (
        .clk_in    (clk_in),
        .rst_N_in  (rst_N_in),
        .flush_in  (flush_in),
        .insn_in   (insn_pkt),
        .ready_out (ready_out),
        .add_bus   (add_bus.dispatch),
        .mult_bus  (mult_bus.dispatch),
        .wb_pkt    (wb_pkt)
    );

    fp_adder #(
        .LATENCY (FP_ADD_LATENCY)
    ) u_adder (
        .clk_in   (clk_in),
        .rst_N_in (rst_N_in),
        .flush_in (flush_in),
        .bus      (add_bus.unit)
    );

    fp_mult_pipe #(
        .LATENCY (FP_MULT_LATENCY)
    ) u_mult (
        .clk_in   (clk_in),
        .rst_N_in (rst_N_in),
        .flush_in (flush_in),
        .bus      (mult_bus.unit)
    );

    phys_regfile u_regfile (
        .clk_in   (clk_in),
        .rst_N_in (rst_N_in),
        .wb_pkt   (wb_pkt),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

endmodule

/* hw/fp_mult_pipe.sv */
module fp_mult_pipe #(
    parameter int LATENCY = 4
) (
    input  logic clk_in,
    input  logic rst_N_in,
    input  logic flush_in,
    fpu_if.unit  bus
);

    localparam int W = reg_pkg::WORD_SIZE;

    logic signed [2*W-1:0] product;
    logic [LATENCY-1:0]    vld_q;
    logic [W-1:0]          res_q [LATENCY];

    // full signed product in Q32.32
    assign product = (2*W)'($signed(bus.a)) * (2*W)'($signed(bus.b));

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            vld_q <= '0;
        end else if (flush_in) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= bus.start;
            for (int i = 1; i < LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // first stage truncates back to Q16.16
    always_ff @(posedge clk_in) begin
        if (bus.start) begin
            res_q[0] <= product[W+15:16];
        end
    end

    // remaining stages only move when a valid word moves with them
    always_ff @(posedge clk_in) begin
        for (int i = 1; i < LATENCY; i++) begin
            if (vld_q[i-1]) begin
                res_q[i] <= res_q[i-1];
            end
        end
    end

    assign bus.result       = res_q[LATENCY-1];
    assign bus.result_valid = vld_q[LATENCY-1];

    a_mult_latency: assert property (@(posedge clk_in) disable iff (!rst_N_in || flush_in)
        bus.start |-> ##LATENCY bus.result_valid);

endmodule

/* hw/fpu_if.sv */
interface fpu_if;

    logic [reg_pkg::WORD_SIZE-1:0] a;
    logic [reg_pkg::WORD_SIZE-1:0] b;
    logic                          start;
    logic [reg_pkg::WORD_SIZE-1:0] result;
    logic                          result_valid;

    // dispatcher side
    modport dispatch (
        output a,
        output b,
        output start,
        input  result,
        input  result_valid
    );

    // arithmetic unit side
    modport unit (
        input  a,
        input  b,
        input  start,
        output result,
        output result_valid
    );

endinterface

/* hw/phys_regfile.sv */
module phys_regfile (
    input  logic                          clk_in,
    input  logic                          rst_N_in,
    input  reg_pkg::reg_write_port        wb_pkt,
    input  reg_pkg::preg_idx_t            rd_index,
    output logic [reg_pkg::WORD_SIZE-1:0] rd_data
);

    logic [reg_pkg::WORD_SIZE-1:0] regs [reg_pkg::NUM_PHYS_REGS];

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            for (int i = 0; i < reg_pkg::NUM_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_pkt.en) begin
            regs[wb_pkt.index] <= wb_pkt.data;
        end
    end

    // combinational read, no bypass of a same-cycle write
    assign rd_data = regs[rd_index];

    a_wr_index_known: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        wb_pkt.en |-> !$isunknown(wb_pkt.index));

endmodule

/* hw/reg_pkg.sv */
package reg_pkg;

    parameter int WORD_SIZE     = 32;
    parameter int NUM_PHYS_REGS = 32;

    // physical register index
    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] preg_idx_t;

    // single regfile write port
    typedef struct packed {
        logic                 en;
        preg_idx_t            index;
        logic [WORD_SIZE-1:0] data;
    } reg_write_port;

endpackage

/* hw/uop_pkg.sv */
package uop_pkg;

    // opcodes seen on the issue port
    typedef enum logic [2:0] {
        UOP_NOP  = 3'd0,
        UOP_ADD  = 3'd1,
        UOP_FADD = 3'd2,
        UOP_FSUB = 3'd3,
        UOP_FMUL = 3'd4
    } uop_e;

    // one execute packet from the issue stage
    // operands are Q16.16 signed fixed-point words
    typedef struct packed {
        logic                             valid;
        uop_e                             uopcode;
        reg_pkg::preg_idx_t               dest_reg_phys;
        logic [reg_pkg::WORD_SIZE-1:0]    r1_val;
        logic [reg_pkg::WORD_SIZE-1:0]    r2_val;
    } exec_packet;

endpackage

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_fp_exec_unit -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

# pass or fail is decided by the pass message alone
echo "$out" | grep -qF "Regression passed"

/* test/tb_fp_exec_unit.sv */
module tb_fp_exec_unit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADD_LAT     = 1;
    localparam int MULT_LAT    = 4;
    localparam int CLK_PERIOD  = 8;
    localparam int NUM_INSN    = 300;
    localparam int WATCHDOG_NS = NUM_INSN * (MULT_LAT + 3) * CLK_PERIOD + 1000;

    logic                clk_in;
    logic                rst_N_in;
    logic                flush_in;
    logic                insn_valid;
    uop_pkg::uop_e       insn_op;
    reg_pkg::preg_idx_t  insn_dest;
    logic [31:0]         insn_r1_val;
    logic [31:0]         insn_r2_val;
    logic                ready_out;
    logic                wb_en;
    reg_pkg::preg_idx_t  wb_index;
    logic [31:0]         wb_data;
    reg_pkg::preg_idx_t  rd_index;
    logic [31:0]         rd_data;

    // shadow copy of the register file
    logic [31:0] shadow [32];

    integer      seed;
    logic [31:0] rnd;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  dest;

    fp_exec_unit #(
        .FP_ADD_LATENCY  (ADD_LAT),
        .FP_MULT_LATENCY (MULT_LAT)
    ) DUT (
        .clk_in      (clk_in),
        .rst_N_in    (rst_N_in),
        .flush_in    (flush_in),
        .insn_valid  (insn_valid),
        .insn_op     (insn_op),
        .insn_dest   (insn_dest),
        .insn_r1_val (insn_r1_val),
        .insn_r2_val (insn_r2_val),
        .ready_out   (ready_out),
        .wb_en       (wb_en),
        .wb_index    (wb_index),
        .wb_data     (wb_data),
        .rd_index    (rd_index),
        .rd_data     (rd_data)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run timed out before all instructions finished");
        $display("Regression failed");
        $fatal(1);
    end

    // Q16.16 reference arithmetic
    function automatic logic [31:0] expected_result(uop_pkg::uop_e op, logic [31:0] a,
                                                    logic [31:0] b);
        logic [63:0] prod;
        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        case (op)
            uop_pkg::UOP_FADD: return a + b;
            uop_pkg::UOP_FSUB: return a - b;
            default:           return prod[47:16];
        endcase
    endfunction

    function automatic int latency_of(uop_pkg::uop_e op);
        return (op == uop_pkg::UOP_FMUL) ? MULT_LAT : ADD_LAT;
    endfunction

    task automatic advance_cycle();
        @(posedge clk_in);
        #1;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAIL %s expected %h got %h", name, exp, got);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (ready_out !== 1'b1 && n < MULT_LAT + 2) begin
            advance_cycle();
            n++;
        end
        assert (ready_out === 1'b1) else begin
            $display("ready_out never came back high before the next issue");
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // one packet for one cycle, returns just after the sampling edge
    task automatic issue_packet(uop_pkg::uop_e op, logic [4:0] d, logic [31:0] a,
                                logic [31:0] b);
        insn_valid  = 1'b1;
        insn_op     = op;
        insn_dest   = d;
        insn_r1_val = a;
        insn_r2_val = b;
        @(posedge clk_in);
        #1;
        insn_valid = 1'b0;
    endtask

    task automatic run_fp(uop_pkg::uop_e op, logic [4:0] d, logic [31:0] a, logic [31:0] b);
        logic [31:0] exp;
        int          lat;
        lat = latency_of(op);
        exp = expected_result(op, a, b);
        wait_ready();
        issue_packet(op, d, a, b);
        for (int k = 1; k <= lat; k++) begin
            @(negedge clk_in);
            check_val("ready_out", 32'h0, 32'(ready_out));
            if (k == lat) begin
                check_val("wb_en", 32'h1, 32'(wb_en));
                check_val("wb_index", 32'(d), 32'(wb_index));
                check_val("wb_data", exp, wb_data);
            end else begin
                check_val("wb_en", 32'h0, 32'(wb_en));
            end
            advance_cycle();
        end
        check_val("ready_out", 32'h1, 32'(ready_out));
        shadow[d] = exp;
    endtask

    task automatic run_non_fp(uop_pkg::uop_e op, logic [4:0] d, logic [31:0] a,
                              logic [31:0] b);
        issue_packet(op, d, a, b);
        for (int k = 1; k <= MULT_LAT; k++) begin
            @(negedge clk_in);
            check_val("wb_en", 32'h0, 32'(wb_en));
            check_val("ready_out", 32'h1, 32'(ready_out));
            advance_cycle();
        end
    endtask

    // flush lands on one of the edges while the result is still in flight
    task automatic run_flushed(uop_pkg::uop_e op, logic [4:0] d, logic [31:0] a,
                               logic [31:0] b, int sel);
        int lat;
        int flush_k;
        lat     = latency_of(op);
        flush_k = 1 + (sel % lat);
        wait_ready();
        issue_packet(op, d, a, b);
        for (int k = 1; k <= lat + 1; k++) begin
            if (k == flush_k) begin
                flush_in = 1'b1;
            end
            @(negedge clk_in);
            check_val("wb_en", 32'h0, 32'(wb_en));
            advance_cycle();
            if (k == flush_k) begin
                flush_in = 1'b0;
                check_val("ready_out", 32'h1, 32'(ready_out));
            end
        end
    endtask

    initial begin
        seed        = 32'h75faebdf;
        rst_N_in    = 1'b0;
        flush_in    = 1'b0;
        insn_valid  = 1'b0;
        insn_op     = uop_pkg::UOP_NOP;
        insn_dest   = '0;
        insn_r1_val = '0;
        insn_r2_val = '0;
        rd_index    = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end

        repeat (4) @(posedge clk_in);
        #1;
        rst_N_in = 1'b1;

        // state right after reset
        for (int i = 0; i < 4; i++) begin
            rd_index = 5'(i * 9);
            @(negedge clk_in);
            check_val("ready_out", 32'h1, 32'(ready_out));
            check_val("wb_en", 32'h0, 32'(wb_en));
            check_val("rd_data", 32'h0, rd_data);
            advance_cycle();
        end

        for (int n = 0; n < NUM_INSN; n++) begin
            rnd  = $random(seed);
            op_a = $random(seed);
            op_b = $random(seed);
            dest = rnd[8:4];
            // small operands now and then so products stay in range
            if (rnd[11]) begin
                op_a = {{12{op_a[19]}}, op_a[19:0]};
                op_b = {{12{op_b[19]}}, op_b[19:0]};
            end
            case (rnd[3:0])
                4'd0, 4'd1, 4'd2, 4'd3: run_fp(uop_pkg::UOP_FADD, dest, op_a, op_b);
                4'd4, 4'd5, 4'd6, 4'd7: run_fp(uop_pkg::UOP_FSUB, dest, op_a, op_b);
                4'd8, 4'd9, 4'd10, 4'd11: run_fp(uop_pkg::UOP_FMUL, dest, op_a, op_b);
                4'd12: run_non_fp(uop_pkg::UOP_ADD, dest, op_a, op_b);
                4'd13: run_non_fp(uop_pkg::UOP_NOP, dest, op_a, op_b);
                default: begin
                    if (rnd[10:9] == 2'd0) begin
                        run_flushed(uop_pkg::UOP_FADD, dest, op_a, op_b, int'(rnd[15:12]));
                    end else if (rnd[10:9] == 2'd1) begin
                        run_flushed(uop_pkg::UOP_FSUB, dest, op_a, op_b, int'(rnd[15:12]));
                    end else begin
                        run_flushed(uop_pkg::UOP_FMUL, dest, op_a, op_b, int'(rnd[15:12]));
                    end
                end
            endcase
        end

        // full readback against the shadow copy
        for (int i = 0; i < 32; i++) begin
            rd_index = 5'(i);
            @(negedge clk_in);
            check_val("rd_data", shadow[i], rd_data);
            advance_cycle();
        end

        $display("Regression passed");
        $finish;
    end

endmodule

/* verilog.f */
hw/reg_pkg.sv
hw/uop_pkg.sv
hw/fpu_if.sv
hw/fp_dispatch.sv
hw/fp_adder.sv
hw/fp_mult_pipe.sv
hw/phys_regfile.sv
hw/fp_exec_unit.sv
test/tb_fp_exec_unit.sv
